/* src.f */
design/cvita_pkg.sv
design/resizer_cfg_pkg.sv
design/resizer_settings.sv
design/resizer_line_counter.sv
design/resizer_drop_fsm.sv
design/resizer_pkt_fifo.sv
design/resizer_output_stage.sv
design/packet_resizer_top.sv
testbench/packet_resizer_checker.sv
testbench/tb_packet_resizer.sv

/* Bender.yml */
package:
  name: packet_resizer

sources:
  - files:
      - design/cvita_pkg.sv
      - design/resizer_cfg_pkg.sv
      - design/resizer_settings.sv
      - design/resizer_line_counter.sv
      - design/resizer_drop_fsm.sv
      - design/resizer_pkt_fifo.sv
      - design/resizer_output_stage.sv
      - design/packet_resizer_top.sv
  - target: test
    files:
      - testbench/packet_resizer_checker.sv
      - testbench/tb_packet_resizer.sv

/* testbench/tb_packet_resizer.sv */
`default_nettype none

module tb_packet_resizer;

  localparam int LIMIT = 4000;

  logic clk, i_arst_n, i_clear, i_set_stb, i_tlast, i_tvalid, i_tready_out;
  logic [7:0] i_set_addr;
  logic [31:0] i_set_data, i_tdata;
  logic [127:0] i_tuser;
  logic o_tready_in, o_tlast, o_tvalid;
  logic [31:0] o_tdata;
  logic [127:0] o_tuser;

  // Model state: expected beats as {last, data}, one header per packet
  logic [32:0] expq[$];
  logic [127:0] hdrq[$];
  int size_bytes = 0, cnt_bytes = 0, pending = 0, cycles = 0, checks = 0;
  int data_errs = 0, hdr_errs = 0, other_errs = 0, total;
  logic drop_mode = 1'b0, bp_on = 1'b0, stall = 1'b0;
  logic [15:0] lfsr_state = 16'd770;
  logic [32:0] exp_beat;
  logic [127:0] exp_hdr;

  packet_resizer_top #(.WIDTH(32), .MAX_PKT_SIZE(4096)) u_packet_resizer_top (.*);

  bind packet_resizer_top packet_resizer_checker #(.WIDTH(WIDTH)) u_checker (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear), .o_tvalid(o_tvalid),
    .i_tready_out(i_tready_out), .o_tdata(o_tdata), .o_tlast(o_tlast),
    .throttle(throttle), .state(u_drop_fsm.state_q));

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles with %0d beats still expected", cycles, expq.size());
      $display("Result: FAILED");
      $finish;
    end
  end

  always @(negedge clk) begin
    i_tready_out = !stall && (!bp_on || random_bits(1) == 32'd1);
  end

  // Output scoreboard, header compared on the closing beat of each packet
  always @(posedge clk) begin
    if (i_arst_n && o_tvalid && i_tready_out) begin
      assert (expq.size() != 0) else begin
        other_errs++;
        $display("Output beat appeared while the model expected none");
      end
      if (expq.size() != 0) begin
        exp_beat = expq.pop_front();
        checks++;
        assert (o_tdata == exp_beat[31:0]) else begin
          data_errs++;
          $display("error: o_tdata got %h expected %h", o_tdata, exp_beat[31:0]);
        end
        assert (o_tlast == exp_beat[32]) else begin
          data_errs++;
          $display("error: o_tlast got %h expected %h", o_tlast, exp_beat[32]);
        end
        if (exp_beat[32] && hdrq.size() != 0) begin
          exp_hdr = hdrq.pop_front();
          assert (o_tuser == exp_hdr) else begin
            hdr_errs++;
            $display("error: o_tuser got %h expected %h", o_tuser, exp_hdr);
          end
        end
      end
    end
  end

  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(negedge clk);
    i_set_stb  = 1'b0;
  endtask

  // Applies the resizing rules to one accepted input beat
  task automatic model_beat(input logic [31:0] data, input logic last, input logic [127:0] hdr);
    logic closes;
    cnt_bytes += 4;
    closes = (cnt_bytes >= size_bytes) || (last && hdr[cvita_pkg::EOB_BIT]);
    if (closes && drop_mode && cnt_bytes < size_bytes) begin
      repeat (pending) void'(expq.pop_back());
      if (hdrq.size() != 0) hdrq[hdrq.size()-1][cvita_pkg::EOB_BIT] = 1'b1;
      pending   = 0;
      cnt_bytes = 0;
    end else begin
      expq.push_back({closes, data});
      pending++;
      if (closes) begin
        hdrq.push_back(hdr);
        pending   = 0;
        cnt_bytes = 0;
      end
    end
  endtask

  task automatic send_words(input int n, input logic last_eob);
    logic [127:0] hdr;
    logic done;
    cvita_pkg::pkt_type_e ptype;
    for (int k = 0; k < n; k++) begin
      ptype = (last_eob && (k == n - 1)) ? cvita_pkg::PKT_DATA_EOB : cvita_pkg::PKT_DATA;
      hdr = '0;
      hdr[31:0] = random_bits(32);
      hdr = cvita_pkg::hdr_set_type(hdr, ptype);
      @(negedge clk);
      i_tdata  = random_bits(32);
      i_tlast  = (k == n - 1);
      i_tuser  = hdr;
      i_tvalid = 1'b1;
      done = 1'b0;
      while (!done) begin
        @(posedge clk);
        done = o_tready_in;
      end
      model_beat(i_tdata, i_tlast, hdr);
    end
    @(negedge clk);
    i_tvalid = 1'b0;
  endtask

  task automatic wait_drain();
    while (expq.size() != 0) @(negedge clk);
    repeat (3) @(negedge clk);
  endtask

  initial begin
    i_arst_n = 1'b0;
    i_clear = 1'b0;
    i_set_stb = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_tdata = '0;
    i_tlast = 1'b0;
    i_tuser = '0;
    i_tvalid = 1'b0;
    i_tready_out = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    i_arst_n = 1'b1;
    write_setting(resizer_cfg_pkg::SR_PKT_SIZE_ADDR, 32'd16);
    size_bytes = 16;
    send_words(12, 1'b0);
    wait_drain();
    // Burst end after six words gives a short second packet
    send_words(6, 1'b1);
    wait_drain();
    write_setting(resizer_cfg_pkg::SR_DROP_ADDR, 32'd3);
    drop_mode = 1'b1;
    send_words(4, 1'b0);
    send_words(2, 1'b1);
    wait_drain();
    write_setting(resizer_cfg_pkg::SR_DROP_ADDR, 32'd0);
    drop_mode = 1'b0;
    bp_on = 1'b1;
    send_words(18, 1'b1);
    wait_drain();
    bp_on = 1'b0;
    stall = 1'b1;
    repeat (3) @(negedge clk);
    send_words(2, 1'b0);
    @(negedge clk);
    i_clear = 1'b1;
    @(negedge clk);
    i_clear = 1'b0;
    // Clear wipes the open words and the settings
    repeat (pending) void'(expq.pop_back());
    pending = 0;
    cnt_bytes = 0;
    write_setting(resizer_cfg_pkg::SR_PKT_SIZE_ADDR, 32'd8);
    size_bytes = 8;
    stall = 1'b0;
    send_words(8, 1'b0);
    wait_drain();
    total = data_errs + hdr_errs + other_errs + u_packet_resizer_top.u_checker.fail_count;
    $display("Beats checked %0d, data errors %0d, header errors %0d, other errors %0d, %s %0d",
             checks, data_errs, hdr_errs, other_errs, "assertion failures",
             u_packet_resizer_top.u_checker.fail_count);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/packet_resizer_checker.sv */
`default_nettype none

module packet_resizer_checker #(
  parameter int WIDTH = 32
) (
  input wire logic                                clk,
  input wire logic                                i_arst_n,
  input wire logic                                i_clear,
  input wire logic                                o_tvalid,
  input wire logic                                i_tready_out,
  input wire logic [WIDTH-1:0]                    o_tdata,
  input wire logic                                o_tlast,
  input wire logic                                throttle,
  input wire resizer_cfg_pkg::drop_state_e        state
);

  int fail_count = 0;

  a_idle_in_reset: assert property (@(posedge clk) !i_arst_n |-> !o_tvalid)
    else begin fail_count++; $error("o_tvalid high during reset"); end

  // A stalled beat keeps its valid, data and last until it moves
  a_stall_stable: assert property (@(posedge clk) disable iff (!i_arst_n || i_clear)
    o_tvalid && !i_tready_out |=> o_tvalid && $stable(o_tdata) && $stable(o_tlast))
    else begin fail_count++; $error("Output beat changed while stalled"); end

  a_throttle_data: assert property (@(posedge clk) disable iff (!i_arst_n || i_clear)
    throttle |=> $stable(o_tdata))
    else begin fail_count++; $error("o_tdata changed during throttle"); end

  a_state_legal: assert property (@(posedge clk) disable iff (!i_arst_n)
    !$isunknown(state) && (state inside {resizer_cfg_pkg::PASS, resizer_cfg_pkg::THROTTLE,
                                         resizer_cfg_pkg::FLUSH, resizer_cfg_pkg::RELEASE}))
    else begin fail_count++; $error("Drop FSM in an illegal state"); end

endmodule

`default_nettype wire

/* design/packet_resizer_top.sv */
`default_nettype none

module packet_resizer_top #(
  parameter int WIDTH        = 32,
  parameter int MAX_PKT_SIZE = 4096
) (
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  logic                        i_clear,
  input  logic                        i_set_stb,
  input  logic [7:0]                  i_set_addr,
  input  logic [31:0]                 i_set_data,
  input  logic [WIDTH-1:0]            i_tdata,
  input  logic                        i_tlast,
  input  logic [cvita_pkg::HDR_W-1:0] i_tuser,
  input  logic                        i_tvalid,
  output logic                        o_tready_in,
  output logic [WIDTH-1:0]            o_tdata,
  output logic                        o_tlast,
  output logic [cvita_pkg::HDR_W-1:0] o_tuser,
  output logic                        o_tvalid,
  input  logic                        i_tready_out
);

  // One full packet plus the same again for a partial one queued behind it
  localparam int BPW        = resizer_cfg_pkg::bytes_per_word(WIDTH);
  localparam int DEPTH_LOG2 = $clog2(MAX_PKT_SIZE / BPW) + 1;

  logic [resizer_cfg_pkg::PKT_SIZE_W-1:0] pkt_size;
  logic [resizer_cfg_pkg::PKT_CNT_W-1:0]  full_pkts;
  logic drop_en, eob_en;
  logic last_int, full_pkt, partial_end;
  logic throttle, fifo_flush, eob_mark, hold_ok;
  logic in_open, fifo_in_ready, beat, rd_open, fifo_valid;
  logic f_valid, f_last, f_ready, out_last_beat, hdr_capture;
  logic [WIDTH-1:0] f_data;

  // A closing word waits while an earlier complete packet is still in the FIFO,
  // so at most two headers are ever waiting for their packets
  assign in_open     = !throttle && !(last_int && (full_pkts != '0));
  assign o_tready_in = fifo_in_ready && in_open;
  assign beat        = i_tvalid && o_tready_in;
  assign partial_end = last_int && !full_pkt;
  assign hdr_capture = beat && last_int && !(drop_en && partial_end);

  // With drop on, nothing leaves the FIFO before a complete packet is in it
  assign rd_open       = !drop_en || ((full_pkts != '0) && !throttle);
  assign f_valid       = fifo_valid && rd_open;
  assign out_last_beat = f_valid && f_ready && f_last;

  resizer_settings u_settings (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .o_pkt_size(pkt_size), .o_drop_en(drop_en), .o_eob_en(eob_en));

  resizer_line_counter #(.WIDTH(WIDTH), .MAX_PKT_SIZE(MAX_PKT_SIZE)) u_line_counter (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear || fifo_flush),
    .i_beat(beat), .i_last(i_tlast), .i_tuser(i_tuser), .i_pkt_size(pkt_size),
    .i_out_last_beat(out_last_beat), .o_last_int(last_int), .o_full_pkt(full_pkt),
    .o_full_pkts(full_pkts));

  resizer_drop_fsm u_drop_fsm (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear),
    .i_drop_en(drop_en), .i_eob_en(eob_en), .i_beat(beat), .i_partial_end(partial_end),
    .i_full_pkts(full_pkts), .o_throttle(throttle), .o_flush(fifo_flush),
    .o_eob_mark(eob_mark), .o_hold_ok(hold_ok));

  resizer_pkt_fifo #(.WIDTH(WIDTH), .DEPTH_LOG2(DEPTH_LOG2)) u_pkt_fifo (
    .clk(clk), .i_arst_n(i_arst_n), .i_flush(i_clear || fifo_flush),
    .i_data(i_tdata), .i_last(last_int), .i_valid(i_tvalid && in_open),
    .i_ready_out(f_ready && rd_open), .o_ready(fifo_in_ready),
    .o_data(f_data), .o_last(f_last), .o_valid(fifo_valid));

  resizer_output_stage #(.WIDTH(WIDTH)) u_output_stage (
    .clk(clk), .i_arst_n(i_arst_n), .i_clear(i_clear),
    .i_data(f_data), .i_last(f_last), .i_valid(f_valid), .i_tuser_in(i_tuser),
    .i_hdr_capture(hdr_capture), .i_hold_ok(hold_ok), .i_eob_mark(eob_mark),
    .i_ready_out(i_tready_out), .o_ready(f_ready), .o_tdata(o_tdata),
    .o_tlast(o_tlast), .o_tuser(o_tuser), .o_tvalid(o_tvalid));

endmodule

`default_nettype wire

/* design/resizer_output_stage.sv */
`default_nettype none

module resizer_output_stage #(
  parameter int WIDTH = 32
) (
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  logic                        i_clear,
  input  logic [WIDTH-1:0]            i_data,
  input  logic                        i_last,
  input  logic                        i_valid,
  input  logic [cvita_pkg::HDR_W-1:0] i_tuser_in,
  input  logic                        i_hdr_capture,
  input  logic                        i_hold_ok,
  input  logic                        i_eob_mark,
  input  logic                        i_ready_out,
  output logic                        o_ready,
  output logic [WIDTH-1:0]            o_tdata,
  output logic                        o_tlast,
  output logic [cvita_pkg::HDR_W-1:0] o_tuser,
  output logic                        o_tvalid
);

  logic                        out_valid;
  logic                        hold;
  logic                        load;
  logic                        out_fire;
  logic                        out_end;
  logic                        eob_flag;
  logic [cvita_pkg::HDR_W-1:0] hdr_mem [2];
  logic                        hdr_wr;
  logic                        hdr_rd;

  // A last word waits here until the next packet is complete or a drop marks EOB
  assign hold     = i_hold_ok && o_tlast && !eob_flag;
  assign o_tvalid = out_valid && !hold;
  assign o_ready  = !out_valid || (i_ready_out && !hold);
  assign load     = i_valid && o_ready;
  assign out_fire = o_tvalid && i_ready_out;
  assign out_end  = out_fire && o_tlast;

  always_ff @(posedge clk) begin
    if (load) begin
      o_tdata <= i_data;
    end
  end

  always_ff @(posedge clk) begin
    if (i_hdr_capture) begin
      hdr_mem[hdr_wr] <= i_tuser_in;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      out_valid <= 1'b0;
      o_tlast   <= 1'b0;
      eob_flag  <= 1'b0;
      hdr_wr    <= 1'b0;
      hdr_rd    <= 1'b0;
    end else if (i_clear) begin
      out_valid <= 1'b0;
      o_tlast   <= 1'b0;
      eob_flag  <= 1'b0;
      hdr_wr    <= 1'b0;
      hdr_rd    <= 1'b0;
    end else begin
      if (load) begin
        out_valid <= 1'b1;
        o_tlast   <= i_last;
      end else if (out_fire) begin
        out_valid <= 1'b0;
      end
      // EOB only goes on a last word that is actually waiting here
      if (out_end) begin
        eob_flag <= 1'b0;
      end else if (i_eob_mark && out_valid && o_tlast) begin
        eob_flag <= 1'b1;
      end
      if (i_hdr_capture) begin
        hdr_wr <= ~hdr_wr;
      end
      if (out_end) begin
        hdr_rd <= ~hdr_rd;
      end
    end
  end

  assign o_tuser = eob_flag ? cvita_pkg::hdr_set_eob(hdr_mem[hdr_rd]) : hdr_mem[hdr_rd];

endmodule

`default_nettype wire

/* design/resizer_pkt_fifo.sv */
`default_nettype none

module resizer_pkt_fifo #(
  parameter int WIDTH      = 32,
  parameter int DEPTH_LOG2 = 11
) (
  input  logic             clk,
  input  logic             i_arst_n,
  input  logic             i_flush,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_last,
  input  logic             i_valid,
  input  logic             i_ready_out,
  output logic             o_ready,
  output logic [WIDTH-1:0] o_data,
  output logic             o_last,
  output logic             o_valid
);

  localparam int DEPTH = 2 ** DEPTH_LOG2;

  logic [WIDTH:0]        mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  push;
  logic                  pop;

  assign o_ready = (count != DEPTH[DEPTH_LOG2:0]);
  assign o_valid = (count != '0);
  assign push    = i_valid && o_ready;
  assign pop     = o_valid && i_ready_out;

  // The head entry is read straight from the array
  assign {o_last, o_data} = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {i_last, i_data};
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (i_flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/resizer_drop_fsm.sv */
`default_nettype none

module resizer_drop_fsm (
  input  logic                                  clk,
  input  logic                                  i_arst_n,
  input  logic                                  i_clear,
  input  logic                                  i_drop_en,
  input  logic                                  i_eob_en,
  input  logic                                  i_beat,
  input  logic                                  i_partial_end,
  input  logic [resizer_cfg_pkg::PKT_CNT_W-1:0] i_full_pkts,
  output logic                                  o_throttle,
  output logic                                  o_flush,
  output logic                                  o_eob_mark,
  output logic                                  o_hold_ok
);

  resizer_cfg_pkg::drop_state_e state_q;
  resizer_cfg_pkg::drop_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      resizer_cfg_pkg::PASS: begin
        if (i_beat && i_partial_end && i_drop_en) begin
          state_d = resizer_cfg_pkg::THROTTLE;
        end
      end
      resizer_cfg_pkg::THROTTLE: begin
        // The partial packet is counted too, so one entry left means only it remains
        if (i_full_pkts <= 1) begin
          state_d = resizer_cfg_pkg::FLUSH;
        end
      end
      resizer_cfg_pkg::FLUSH: begin
        state_d = resizer_cfg_pkg::RELEASE;
      end
      default: begin
        state_d = resizer_cfg_pkg::PASS;
      end
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= resizer_cfg_pkg::PASS;
    end else if (i_clear) begin
      state_q <= resizer_cfg_pkg::PASS;
    end else begin
      state_q <= state_d;
    end
  end

  // Input stays closed from the partial packet's last word until the FIFO is emptied
  assign o_throttle = (state_q == resizer_cfg_pkg::THROTTLE) ||
                      (state_q == resizer_cfg_pkg::FLUSH);
  assign o_flush    = (state_q == resizer_cfg_pkg::FLUSH);
  assign o_eob_mark = (state_q == resizer_cfg_pkg::FLUSH) && i_eob_en;

  // Hold the previous last line while no complete packet follows it,
  // and through a drop so that EOB can still be put on it
  assign o_hold_ok = i_drop_en && i_eob_en &&
                     (((state_q == resizer_cfg_pkg::PASS) && (i_full_pkts == '0)) ||
                      (state_q == resizer_cfg_pkg::THROTTLE) ||
                      (state_q == resizer_cfg_pkg::FLUSH));

endmodule

`default_nettype wire

/* design/resizer_line_counter.sv */
`default_nettype none

module resizer_line_counter #(
  parameter int WIDTH        = 32,
  parameter int MAX_PKT_SIZE = 4096
) (
  input  logic                                   clk,
  input  logic                                   i_arst_n,
  input  logic                                   i_clear,
  input  logic                                   i_beat,
  input  logic                                   i_last,
  input  logic [cvita_pkg::HDR_W-1:0]            i_tuser,
  input  logic [resizer_cfg_pkg::PKT_SIZE_W-1:0] i_pkt_size,
  input  logic                                   i_out_last_beat,
  output logic                                   o_last_int,
  output logic                                   o_full_pkt,
  output logic [resizer_cfg_pkg::PKT_CNT_W-1:0]  o_full_pkts
);

  localparam int BPW   = resizer_cfg_pkg::bytes_per_word(WIDTH);
  localparam int CNT_W = $clog2(MAX_PKT_SIZE + 1);

  logic [CNT_W-1:0] byte_cnt;
  logic             size_hit;
  logic             pkt_in;

  // The count already includes the word on the bus, so it starts at one word
  assign size_hit   = (byte_cnt >= i_pkt_size);
  assign o_last_int = size_hit || (i_last && cvita_pkg::hdr_eob(i_tuser));
  assign o_full_pkt = i_beat && size_hit;
  assign pkt_in     = i_beat && o_last_int;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      byte_cnt <= CNT_W'(BPW);
    end else if (i_clear) begin
      byte_cnt <= CNT_W'(BPW);
    end else if (i_beat) begin
      byte_cnt <= o_last_int ? CNT_W'(BPW) : byte_cnt + CNT_W'(BPW);
    end
  end

  // Packets closed on the input side whose last word is still in the FIFO
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_full_pkts <= '0;
    end else if (i_clear) begin
      o_full_pkts <= '0;
    end else begin
      case ({pkt_in, i_out_last_beat})
        2'b10:   o_full_pkts <= o_full_pkts + 1'b1;
        2'b01:   o_full_pkts <= o_full_pkts - 1'b1;
        default: o_full_pkts <= o_full_pkts;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/resizer_settings.sv */
`default_nettype none

module resizer_settings (
  input  logic                                  clk,
  input  logic                                  i_arst_n,
  input  logic                                  i_clear,
  input  logic                                  i_set_stb,
  input  logic [7:0]                            i_set_addr,
  input  logic [31:0]                           i_set_data,
  output logic [resizer_cfg_pkg::PKT_SIZE_W-1:0] o_pkt_size,
  output logic                                  o_drop_en,
  output logic                                  o_eob_en
);

  logic wr_size;
  logic wr_drop;

  assign wr_size = i_set_stb && (i_set_addr == resizer_cfg_pkg::SR_PKT_SIZE_ADDR);
  assign wr_drop = i_set_stb && (i_set_addr == resizer_cfg_pkg::SR_DROP_ADDR);

  // A write is visible on the cycle after its strobe
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_pkt_size <= '0;
      o_drop_en  <= 1'b0;
      o_eob_en   <= 1'b0;
    end else if (i_clear) begin
      o_pkt_size <= '0;
      o_drop_en  <= 1'b0;
      o_eob_en   <= 1'b0;
    end else begin
      if (wr_size) begin
        o_pkt_size <= i_set_data[resizer_cfg_pkg::PKT_SIZE_W-1:0];
      end
      if (wr_drop) begin
        o_drop_en <= i_set_data[resizer_cfg_pkg::DROP_EN_BIT];
        o_eob_en  <= i_set_data[resizer_cfg_pkg::EOB_EN_BIT];
      end
    end
  end

endmodule

`default_nettype wire

/* design/resizer_cfg_pkg.sv */
`default_nettype none

package resizer_cfg_pkg;

  // Settings bus register map
  localparam logic [7:0] SR_PKT_SIZE_ADDR = 8'd0;
  localparam logic [7:0] SR_DROP_ADDR     = 8'd1;

  // Bits of the drop control word
  localparam int DROP_EN_BIT = 0;
  localparam int EOB_EN_BIT  = 1;

  // Packet size register width and full packet counter width
  localparam int PKT_SIZE_W = 16;
  localparam int PKT_CNT_W  = 16;

  typedef enum logic [1:0] {
    PASS     = 2'd0,
    THROTTLE = 2'd1,
    FLUSH    = 2'd2,
    RELEASE  = 2'd3
  } drop_state_e;

  // Data words are always a whole number of bytes
  function automatic int bytes_per_word(input int width);
    return width / 8;
  endfunction

endpackage

`default_nettype wire

/* design/cvita_pkg.sv */
`default_nettype none

package cvita_pkg;

  // Width of the header sideband that travels with each packet
  localparam int HDR_W = 128;

  // Field positions in the header, counted from bit 0 of the sideband
  localparam int PKT_TYPE_HI = 127;
  localparam int PKT_TYPE_LO = 126;
  localparam int EOB_BIT     = 124;

  // Packet type as seen by the data path, the EOB flag folded into the low bit
  typedef enum logic [2:0] {
    PKT_DATA     = 3'b000,
    PKT_DATA_EOB = 3'b001,
    PKT_FC       = 3'b010,
    PKT_CMD      = 3'b100,
    PKT_RESP     = 3'b110
  } pkt_type_e;

  function automatic logic hdr_eob(input logic [HDR_W-1:0] hdr);
    return hdr[EOB_BIT];
  endfunction

  function automatic logic [HDR_W-1:0] hdr_set_eob(input logic [HDR_W-1:0] hdr);
    logic [HDR_W-1:0] res;
    res          = hdr;
    res[EOB_BIT] = 1'b1;
    return res;
  endfunction

  function automatic pkt_type_e hdr_pkt_type(input logic [HDR_W-1:0] hdr);
    pkt_type_e res;
    case (hdr[PKT_TYPE_HI:PKT_TYPE_LO])
      2'b00:   res = hdr[EOB_BIT] ? PKT_DATA_EOB : PKT_DATA;
      2'b01:   res = PKT_FC;
      2'b10:   res = PKT_CMD;
      default: res = PKT_RESP;
    endcase
    return res;
  endfunction

  // Writes the type field, and the EOB bit for data packets only
  function automatic logic [HDR_W-1:0] hdr_set_type(input logic [HDR_W-1:0] hdr,
                                                    input pkt_type_e       ptype);
    logic [HDR_W-1:0] res;
    res                          = hdr;
    res[PKT_TYPE_HI:PKT_TYPE_LO] = ptype[2:1];
    res[EOB_BIT]                 = (ptype == PKT_DATA_EOB);
    return res;
  endfunction

endpackage

`default_nettype wire
